// ==== rtl/dmi_params.svh ====
// widths, slave count and slave base addresses, included by the package, the RTL and the testbench
`ifndef DMI_PARAMS_SVH
`define DMI_PARAMS_SVH

// bus data width
`define DMI_DATA_W 32

// offset inside one slave window
`define DMI_LOW_ADDR_W 12

// slave select bits above the offset
`define DMI_HIGH_ADDR_W 2

`define DMI_ADDR_W (`DMI_LOW_ADDR_W + `DMI_HIGH_ADDR_W)

// high value 3 is left unmapped
`define DMI_SLAVE_NUM 3

// one 4 KiB window per slave
`define DMI_SLAVE_0_BASE 'h0000
`define DMI_SLAVE_1_BASE 'h1000
`define DMI_SLAVE_2_BASE 'h2000

`endif

// ==== rtl/dmi_pkg.sv ====
// shared operation, state and bus-owner types, imported by every RTL module
`include "dmi_params.svh"

package dmi_pkg;

    // matches the op field of a DMI request
    typedef enum logic [1:0] {
        op_nop   = 2'd0,
        op_read  = 2'd1,
        op_write = 2'd2,
        op_rsvd  = 2'd3
    } dmi_op_t;

    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_setup  = 2'd1,
        st_access = 2'd2
    } apb_state_t;

    typedef enum logic [1:0] {
        own_none   = 2'd0,
        own_debug  = 2'd1,
        own_system = 2'd2
    } bus_owner_t;

    typedef logic [`DMI_ADDR_W-1:0] dmi_addr_t;
    typedef logic [`DMI_DATA_W-1:0] dmi_data_t;

endpackage

// ==== rtl/dmi_apb_master.sv ====
// APB master that runs one debug command at a time and reports its result with a done pulse
`timescale 1ns/1ns
`include "dmi_params.svh"

module dmi_apb_master import dmi_pkg::*; (
    input  logic       sys_apb_clk,
    input  logic       reset,

    // debug command port
    input  logic       cmd_vld,
    input  dmi_op_t    cmd_op,
    input  dmi_addr_t  cmd_addr,
    input  dmi_data_t  cmd_wdata,
    output logic       busy,
    output logic       cmd_done,
    output dmi_data_t  cmd_rdata,
    output logic       cmd_err,

    // APB master side
    output logic       dbg_psel,
    output logic       dbg_penable,
    output logic       dbg_pwrite,
    output dmi_addr_t  dbg_paddr,
    output dmi_data_t  dbg_pwdata,
    input  logic       dbg_pready,
    input  logic       dbg_pslverr,
    input  dmi_data_t  dbg_prdata
);

    apb_state_t state;
    logic       is_bus_op;
    logic       start;
    logic       xfer_end;

    // reserved op behaves like a nop
    assign is_bus_op = (cmd_op == op_read) || (cmd_op == op_write);
    assign start     = (state == st_idle) && cmd_vld;
    assign xfer_end  = (state == st_access) && dbg_pready;

    assign dbg_psel    = (state != st_idle);
    assign dbg_penable = (state == st_access);

    always_ff @(posedge sys_apb_clk) begin
        if (reset) begin
            state     <= st_idle;
            busy      <= 1'b0;
            cmd_done  <= 1'b0;
            cmd_rdata <= '0;
            cmd_err   <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            // busy drops after the done cycle
            if (cmd_done) begin
                busy <= 1'b0;
            end
            case (state)
                st_idle: begin
                    if (cmd_vld) begin
                        busy <= 1'b1;
                        if (is_bus_op) begin
                            state <= st_setup;
                        end else begin
                            cmd_done <= 1'b1;
                            cmd_err  <= 1'b0;
                        end
                    end
                end
                st_setup: begin
                    state <= st_access;
                end
                st_access: begin
                    if (xfer_end) begin
                        state    <= st_idle;
                        cmd_done <= 1'b1;
                        cmd_err  <= dbg_pslverr;
                        // writes report zero read data
                        cmd_rdata <= dbg_pwrite ? '0 : dbg_prdata;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // command payload, held stable for the whole transfer
    always_ff @(posedge sys_apb_clk) begin
        if (start && is_bus_op) begin
            dbg_paddr  <= cmd_addr;
            dbg_pwdata <= cmd_wdata;
            dbg_pwrite <= (cmd_op == op_write);
        end
    end

endmodule

// ==== rtl/dmi_apb_mux.sv ====
// shares the downstream APB bus between the debug master and the system port, system first
`timescale 1ns/1ns
`include "dmi_params.svh"

module dmi_apb_mux import dmi_pkg::*; (
    input  logic       sys_apb_clk,
    input  logic       reset,

    // debug master
    input  logic       dbg_psel,
    input  logic       dbg_penable,
    input  logic       dbg_pwrite,
    input  dmi_addr_t  dbg_paddr,
    input  dmi_data_t  dbg_pwdata,
    output logic       dbg_pready,
    output logic       dbg_pslverr,
    output dmi_data_t  dbg_prdata,

    // system port
    input  logic       sys_apb_en,
    input  logic       sys_psel,
    input  logic       sys_penable,
    input  logic       sys_pwrite,
    input  dmi_addr_t  sys_paddr,
    input  dmi_data_t  sys_pwdata,
    output logic       sys_pready,
    output logic       sys_pslverr,
    output dmi_data_t  sys_prdata,

    // towards the decoder
    output logic       bus_psel,
    output logic       bus_penable,
    output logic       bus_pwrite,
    output dmi_addr_t  bus_paddr,
    output dmi_data_t  bus_pwdata,
    input  logic       bus_pready,
    input  logic       bus_pslverr,
    input  dmi_data_t  bus_prdata
);

    bus_owner_t owner_q;
    bus_owner_t arb_owner;
    bus_owner_t cur_owner;
    logic       grant_new;
    logic       sel_penable;
    logic       xfer_end;
    logic       dbg_owns;
    logic       sys_owns;

    always_comb begin
        if (sys_apb_en && sys_psel) begin
            arb_owner = own_system;
        end else if (dbg_psel) begin
            arb_owner = own_debug;
        end else begin
            arb_owner = own_none;
        end
    end

    // while idle the winner is granted in the same cycle
    assign grant_new = (owner_q == own_none);
    assign cur_owner = grant_new ? arb_owner : owner_q;

    always_comb begin
        bus_psel    = 1'b0;
        sel_penable = 1'b0;
        bus_pwrite  = 1'b0;
        bus_paddr   = '0;
        bus_pwdata  = '0;
        case (cur_owner)
            own_system: begin
                bus_psel    = sys_psel;
                sel_penable = sys_penable;
                bus_pwrite  = sys_pwrite;
                bus_paddr   = sys_paddr;
                bus_pwdata  = sys_pwdata;
            end
            own_debug: begin
                bus_psel    = dbg_psel;
                sel_penable = dbg_penable;
                bus_pwrite  = dbg_pwrite;
                bus_paddr   = dbg_paddr;
                bus_pwdata  = dbg_pwdata;
            end
            default: begin
            end
        endcase
    end

    // the grant cycle is always a setup phase downstream, even for a requester
    // that has already moved on to its access phase while waiting
    assign bus_penable = !grant_new && sel_penable;
    assign xfer_end    = bus_penable && bus_pready;

    assign dbg_owns    = (owner_q == own_debug);
    assign sys_owns    = (owner_q == own_system);
    assign dbg_pready  = dbg_owns && bus_pready;
    assign dbg_pslverr = dbg_owns && bus_pslverr;
    assign dbg_prdata  = dbg_owns ? bus_prdata : '0;
    assign sys_pready  = sys_owns && bus_pready;
    assign sys_pslverr = sys_owns && bus_pslverr;
    assign sys_prdata  = sys_owns ? bus_prdata : '0;

    always_ff @(posedge sys_apb_clk) begin
        if (reset) begin
            owner_q <= own_none;
        end else if (xfer_end) begin
            owner_q <= own_none;
        end else if (grant_new) begin
            owner_q <= arb_owner;
        end
    end

endmodule

// ==== rtl/dmi_apb_decoder.sv ====
// APB address decoder that picks one slave by the high address bits and errors on unmapped space
`timescale 1ns/1ns
`include "dmi_params.svh"

module dmi_apb_decoder import dmi_pkg::*; (
    // from the mux
    input  logic                                   bus_psel,
    input  logic                                   bus_penable,
    input  logic                                   bus_pwrite,
    input  dmi_addr_t                              bus_paddr,
    input  dmi_data_t                              bus_pwdata,
    output logic                                   bus_pready,
    output logic                                   bus_pslverr,
    output dmi_data_t                              bus_prdata,

    // slave side
    output logic [`DMI_SLAVE_NUM-1:0]              slv_psel,
    output logic                                   slv_penable,
    output logic                                   slv_pwrite,
    output logic [`DMI_LOW_ADDR_W-1:0]             slv_paddr,
    output dmi_data_t                              slv_pwdata,
    input  logic [`DMI_SLAVE_NUM*`DMI_DATA_W-1:0]  slv_prdata,
    input  logic [`DMI_SLAVE_NUM-1:0]              slv_pready,
    input  logic [`DMI_SLAVE_NUM-1:0]              slv_pslverr
);

    localparam dmi_addr_t SLAVE_BASE [`DMI_SLAVE_NUM] = '{
        `DMI_SLAVE_0_BASE,
        `DMI_SLAVE_1_BASE,
        `DMI_SLAVE_2_BASE
    };

    logic [`DMI_HIGH_ADDR_W-1:0] high_addr;
    logic [`DMI_SLAVE_NUM-1:0]   hit;
    logic                        mapped;

    assign high_addr = bus_paddr[`DMI_ADDR_W-1:`DMI_LOW_ADDR_W];

    always_comb begin
        for (int n = 0; n < `DMI_SLAVE_NUM; n++) begin
            hit[n] = (high_addr == SLAVE_BASE[n][`DMI_ADDR_W-1:`DMI_LOW_ADDR_W]);
        end
    end

    assign mapped = |hit;

    // request side, no select and no enable for a hole in the map
    assign slv_psel    = hit & {`DMI_SLAVE_NUM{bus_psel}};
    assign slv_penable = bus_penable && mapped;
    assign slv_pwrite  = bus_pwrite;
    assign slv_paddr   = bus_paddr[`DMI_LOW_ADDR_W-1:0];
    assign slv_pwdata  = bus_pwdata;

    // response side
    always_comb begin
        // unmapped default, completes at once with an error in the access phase
        bus_pready  = 1'b1;
        bus_pslverr = bus_penable;
        bus_prdata  = '0;
        for (int n = 0; n < `DMI_SLAVE_NUM; n++) begin
            if (hit[n]) begin
                bus_pready  = slv_pready[n];
                bus_pslverr = slv_pslverr[n];
                bus_prdata  = slv_prdata[n*`DMI_DATA_W +: `DMI_DATA_W];
            end
        end
    end

endmodule

// ==== rtl/dmi_top.sv ====
// top level of the debug bus path, wiring the APB master, the bus mux and the slave decoder
`timescale 1ns/1ns
`include "dmi_params.svh"

module dmi_top import dmi_pkg::*; (
    input  logic                                   sys_apb_clk,
    input  logic                                   reset,

    // debug command port
    input  logic                                   cmd_vld,
    input  dmi_op_t                                cmd_op,
    input  dmi_addr_t                              cmd_addr,
    input  dmi_data_t                              cmd_wdata,
    output logic                                   busy,
    output logic                                   cmd_done,
    output dmi_data_t                              cmd_rdata,
    output logic                                   cmd_err,

    // system APB port
    input  logic                                   sys_apb_en,
    input  logic                                   sys_psel,
    input  logic                                   sys_penable,
    input  logic                                   sys_pwrite,
    input  dmi_addr_t                              sys_paddr,
    input  dmi_data_t                              sys_pwdata,
    output logic                                   sys_pready,
    output logic                                   sys_pslverr,
    output dmi_data_t                              sys_prdata,

    // slave bus
    output logic [`DMI_SLAVE_NUM-1:0]              slv_psel,
    output logic                                   slv_penable,
    output logic                                   slv_pwrite,
    output logic [`DMI_LOW_ADDR_W-1:0]             slv_paddr,
    output dmi_data_t                              slv_pwdata,
    input  logic [`DMI_SLAVE_NUM*`DMI_DATA_W-1:0]  slv_prdata,
    input  logic [`DMI_SLAVE_NUM-1:0]              slv_pready,
    input  logic [`DMI_SLAVE_NUM-1:0]              slv_pslverr
);

    // master to mux
    logic      dbg_psel;
    logic      dbg_penable;
    logic      dbg_pwrite;
    dmi_addr_t dbg_paddr;
    dmi_data_t dbg_pwdata;
    logic      dbg_pready;
    logic      dbg_pslverr;
    dmi_data_t dbg_prdata;

    // mux to decoder
    logic      bus_psel;
    logic      bus_penable;
    logic      bus_pwrite;
    dmi_addr_t bus_paddr;
    dmi_data_t bus_pwdata;
    logic      bus_pready;
    logic      bus_pslverr;
    dmi_data_t bus_prdata;

    dmi_apb_master master_i (
        .sys_apb_clk (sys_apb_clk),
        .reset       (reset),
        .cmd_vld     (cmd_vld),
        .cmd_op      (cmd_op),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .busy        (busy),
        .cmd_done    (cmd_done),
        .cmd_rdata   (cmd_rdata),
        .cmd_err     (cmd_err),
        .dbg_psel    (dbg_psel),
        .dbg_penable (dbg_penable),
        .dbg_pwrite  (dbg_pwrite),
        .dbg_paddr   (dbg_paddr),
        .dbg_pwdata  (dbg_pwdata),
        .dbg_pready  (dbg_pready),
        .dbg_pslverr (dbg_pslverr),
        .dbg_prdata  (dbg_prdata)
    );

    dmi_apb_mux mux_i (
        .sys_apb_clk (sys_apb_clk),
        .reset       (reset),
        .dbg_psel    (dbg_psel),
        .dbg_penable (dbg_penable),
        .dbg_pwrite  (dbg_pwrite),
        .dbg_paddr   (dbg_paddr),
        .dbg_pwdata  (dbg_pwdata),
        .dbg_pready  (dbg_pready),
        .dbg_pslverr (dbg_pslverr),
        .dbg_prdata  (dbg_prdata),
        .sys_apb_en  (sys_apb_en),
        .sys_psel    (sys_psel),
        .sys_penable (sys_penable),
        .sys_pwrite  (sys_pwrite),
        .sys_paddr   (sys_paddr),
        .sys_pwdata  (sys_pwdata),
        .sys_pready  (sys_pready),
        .sys_pslverr (sys_pslverr),
        .sys_prdata  (sys_prdata),
        .bus_psel    (bus_psel),
        .bus_penable (bus_penable),
        .bus_pwrite  (bus_pwrite),
        .bus_paddr   (bus_paddr),
        .bus_pwdata  (bus_pwdata),
        .bus_pready  (bus_pready),
        .bus_pslverr (bus_pslverr),
        .bus_prdata  (bus_prdata)
    );

    dmi_apb_decoder decoder_i (
        .bus_psel    (bus_psel),
        .bus_penable (bus_penable),
        .bus_pwrite  (bus_pwrite),
        .bus_paddr   (bus_paddr),
        .bus_pwdata  (bus_pwdata),
        .bus_pready  (bus_pready),
        .bus_pslverr (bus_pslverr),
        .bus_prdata  (bus_prdata),
        .slv_psel    (slv_psel),
        .slv_penable (slv_penable),
        .slv_pwrite  (slv_pwrite),
        .slv_paddr   (slv_paddr),
        .slv_pwdata  (slv_pwdata),
        .slv_prdata  (slv_prdata),
        .slv_pready  (slv_pready),
        .slv_pslverr (slv_pslverr)
    );

endmodule

// ==== dv/dmi_properties.sv ====
// APB protocol and command port assertions that are bound into dmi_top
`timescale 1ns/1ns
`include "dmi_params.svh"

module dmi_properties import dmi_pkg::*; (
    input logic                      sys_apb_clk,
    input logic                      reset,
    input logic                      busy,
    input logic                      cmd_done,
    input logic                      dbg_psel,
    input logic                      dbg_penable,
    input logic                      dbg_pwrite,
    input logic                      dbg_pready,
    input dmi_addr_t                 dbg_paddr,
    input dmi_data_t                 dbg_pwdata,
    input logic                      sys_psel,
    input logic                      sys_penable,
    input logic                      bus_psel,
    input logic                      bus_penable,
    input logic                      bus_pready,
    input dmi_addr_t                 bus_paddr,
    input dmi_data_t                 bus_pwdata,
    input logic [`DMI_SLAVE_NUM-1:0] slv_psel,
    input logic                      slv_penable
);

    a_slv_onehot: assert property (@(posedge sys_apb_clk) disable iff (reset)
        $onehot0(slv_psel)) else $error("more than one slave selected");

    a_dbg_pen: assert property (@(posedge sys_apb_clk) disable iff (reset)
        dbg_penable |-> dbg_psel) else $error("debug penable without psel");
    a_sys_pen: assert property (@(posedge sys_apb_clk) disable iff (reset)
        sys_penable |-> sys_psel) else $error("system penable without psel");
    a_bus_pen: assert property (@(posedge sys_apb_clk) disable iff (reset)
        bus_penable |-> bus_psel) else $error("bus penable without psel");
    a_slv_pen: assert property (@(posedge sys_apb_clk) disable iff (reset)
        slv_penable |-> |slv_psel) else $error("slave penable without a select");

    // payload holds from setup until the completing access cycle
    a_dbg_stable: assert property (@(posedge sys_apb_clk) disable iff (reset)
        (dbg_psel && !(dbg_penable && dbg_pready)) |=>
        ($stable(dbg_paddr) && $stable(dbg_pwdata) && $stable(dbg_pwrite)))
        else $error("debug address or data changed during a transfer");
    a_bus_stable: assert property (@(posedge sys_apb_clk) disable iff (reset)
        (bus_psel && !(bus_penable && bus_pready)) |=>
        ($stable(bus_paddr) && $stable(bus_pwdata)))
        else $error("bus address or data changed during a transfer");

    a_done_busy: assert property (@(posedge sys_apb_clk) disable iff (reset)
        cmd_done |-> busy) else $error("command done while not busy");

endmodule

bind dmi_top dmi_properties props_i (.*);

// ==== dv/dmi_tb.sv ====
// testbench for dmi_top that replays the golden step file through the debug and system ports
`timescale 1ns/1ns
`include "dmi_params.svh"

module dmi_tb import dmi_pkg::*; ();

    localparam int DRV_DLY = 1;
    localparam int RSP_DLY = 2;
    localparam int SMP_DLY = 3;
    localparam int WORDS   = 256;

    logic                                   sys_apb_clk;
    logic                                   reset;
    logic                                   cmd_vld;
    dmi_op_t                                cmd_op;
    dmi_addr_t                              cmd_addr;
    dmi_data_t                              cmd_wdata;
    logic                                   busy;
    logic                                   cmd_done;
    dmi_data_t                              cmd_rdata;
    logic                                   cmd_err;
    logic                                   sys_apb_en;
    logic                                   sys_psel;
    logic                                   sys_penable;
    logic                                   sys_pwrite;
    dmi_addr_t                              sys_paddr;
    dmi_data_t                              sys_pwdata;
    logic                                   sys_pready;
    logic                                   sys_pslverr;
    dmi_data_t                              sys_prdata;
    logic [`DMI_SLAVE_NUM-1:0]              slv_psel;
    logic                                   slv_penable;
    logic                                   slv_pwrite;
    logic [`DMI_LOW_ADDR_W-1:0]             slv_paddr;
    dmi_data_t                              slv_pwdata;
    logic [`DMI_SLAVE_NUM*`DMI_DATA_W-1:0]  slv_prdata;
    logic [`DMI_SLAVE_NUM-1:0]              slv_pready;
    logic [`DMI_SLAVE_NUM-1:0]              slv_pslverr;

    // slave models holding 1 KiB of words each
    dmi_data_t                 mem [`DMI_SLAVE_NUM][WORDS];
    int                        wait_left [`DMI_SLAVE_NUM];
    logic [`DMI_SLAVE_NUM-1:0] in_access;

    // steps read from the golden file
    logic [7:0] port_q [$];
    logic [1:0] op_q [$];
    dmi_addr_t  addr_q [$];
    dmi_data_t  wdata_q [$];
    dmi_data_t  rdata_q [$];
    logic       err_q [$];

    int errors;
    int cycles;
    int cycle_limit;

    dmi_top dut_i (.*);

    initial sys_apb_clk = 1'b0;
    always #2 sys_apb_clk = ~sys_apb_clk;

    // slaves answer mid-cycle between the drivers and the samplers
    always @(posedge sys_apb_clk) begin
        #RSP_DLY;
        for (int n = 0; n < `DMI_SLAVE_NUM; n++) begin
            if (slv_psel[n] && slv_penable) begin
                if (!in_access[n]) begin
                    in_access[n] = 1'b1;
                    wait_left[n] = $urandom_range(2, 0);
                end else if (wait_left[n] != 0) begin
                    wait_left[n]--;
                end
                slv_pready[n] = (wait_left[n] == 0);
                // word index inside the 1 KiB window
                if (slv_pready[n] && slv_pwrite) begin
                    mem[n][slv_paddr[9:2]] = slv_pwdata;
                end
                slv_prdata[n*`DMI_DATA_W +: `DMI_DATA_W] = mem[n][slv_paddr[9:2]];
            end else begin
                in_access[n]  = 1'b0;
                slv_pready[n] = 1'b0;
            end
        end
    end

    always @(posedge sys_apb_clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the run went past %0d cycles", cycle_limit);
            $display("errors: %0d", errors + 1);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic debug_cmd(input logic [1:0] op, input dmi_addr_t addr,
                             input dmi_data_t wdata, input dmi_data_t exp_rdata,
                             input logic exp_err, output time done_t);
        @(posedge sys_apb_clk);
        #DRV_DLY;
        cmd_vld   = 1'b1;
        cmd_op    = dmi_op_t'(op);
        cmd_addr  = addr;
        cmd_wdata = wdata;
        @(posedge sys_apb_clk);
        #DRV_DLY;
        cmd_vld = 1'b0;
        #(SMP_DLY - DRV_DLY);
        while (!cmd_done) begin
            @(posedge sys_apb_clk);
            #SMP_DLY;
        end
        done_t = $time;
        check_value("cmd_rdata", exp_rdata, cmd_rdata);
        check_value("cmd_err", exp_err, cmd_err);
        if (op == op_nop || op == op_rsvd) begin
            check_value("slv_psel", '0, slv_psel);
        end
    endtask

    task automatic sys_xfer(input logic [1:0] op, input dmi_addr_t addr,
                            input dmi_data_t wdata, input dmi_data_t exp_rdata,
                            input logic exp_err, output time end_t);
        @(posedge sys_apb_clk);
        #DRV_DLY;
        sys_apb_en  = 1'b1;
        sys_psel    = 1'b1;
        sys_penable = 1'b0;
        sys_pwrite  = (op == op_write);
        sys_paddr   = addr;
        sys_pwdata  = wdata;
        @(posedge sys_apb_clk);
        #DRV_DLY;
        sys_penable = 1'b1;
        #(SMP_DLY - DRV_DLY);
        while (!sys_pready) begin
            @(posedge sys_apb_clk);
            #SMP_DLY;
        end
        end_t = $time;
        if (op != op_write) begin
            check_value("sys_prdata", exp_rdata, sys_prdata);
        end
        check_value("sys_pslverr", exp_err, sys_pslverr);
        @(posedge sys_apb_clk);
        #DRV_DLY;
        sys_psel    = 1'b0;
        sys_penable = 1'b0;
        sys_apb_en  = 1'b0;
    endtask

    initial begin
        int          fd;
        int          fields;
        string       line;
        logic [7:0]  port_c;
        logic [31:0] op_v;
        logic [31:0] addr_v;
        logic [31:0] wdata_v;
        logic [31:0] rdata_v;
        logic [31:0] err_v;
        time         sys_t;
        time         dbg_t;

        void'($urandom(32'hda652e2a));
        reset       = 1'b1;
        cmd_vld     = 1'b0;
        cmd_op      = op_nop;
        cmd_addr    = '0;
        cmd_wdata   = '0;
        sys_apb_en  = 1'b0;
        sys_psel    = 1'b0;
        sys_penable = 1'b0;
        sys_pwrite  = 1'b0;
        sys_paddr   = '0;
        sys_pwdata  = '0;
        slv_prdata  = '0;
        slv_pready  = '0;
        slv_pslverr = '0;
        in_access   = '0;
        for (int n = 0; n < `DMI_SLAVE_NUM; n++) begin
            wait_left[n] = 0;
            // fill carries the full word address
            for (int i = 0; i < WORDS; i++) begin
                mem[n][i] = 32'ha500_0000 | (n << `DMI_LOW_ADDR_W) | (i << 2);
            end
        end

        fd = $fopen("dv/dmi_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the golden file dv/dmi_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    fields = $sscanf(line, "%c %h %h %h %h %h", port_c, op_v, addr_v,
                                     wdata_v, rdata_v, err_v);
                    if (fields == 6) begin
                        port_q.push_back(port_c);
                        op_q.push_back(op_v[1:0]);
                        addr_q.push_back(addr_v[`DMI_ADDR_W-1:0]);
                        wdata_q.push_back(wdata_v);
                        rdata_q.push_back(rdata_v);
                        err_q.push_back(err_v[0]);
                    end else begin
                        errors++;
                        $display("golden file line could not be parsed: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        cycle_limit = port_q.size() * 12 + 50;

        repeat (3) @(posedge sys_apb_clk);
        #DRV_DLY;
        reset = 1'b0;
        #(SMP_DLY - DRV_DLY);
        check_value("busy", '0, busy);
        check_value("cmd_done", '0, cmd_done);
        check_value("sys_pready", '0, sys_pready);
        check_value("slv_psel", '0, slv_psel);

        for (int i = 0; i < port_q.size(); i++) begin
            repeat ($urandom_range(3, 0)) @(posedge sys_apb_clk);
            case (port_q[i])
                "d": debug_cmd(op_q[i], addr_q[i], wdata_q[i], rdata_q[i], err_q[i], dbg_t);
                "s": sys_xfer(op_q[i], addr_q[i], wdata_q[i], rdata_q[i], err_q[i], sys_t);
                "c": begin
                    // debug reads back the same address once the system side is under way
                    fork
                        sys_xfer(op_q[i], addr_q[i], wdata_q[i], rdata_q[i], err_q[i], sys_t);
                        begin
                            repeat (2) @(posedge sys_apb_clk);
                            debug_cmd(op_read, addr_q[i], '0, rdata_q[i], err_q[i], dbg_t);
                        end
                    join
                    check_value("sys_done_first", 32'd1, {31'd0, sys_t < dbg_t});
                end
                default: begin
                    errors++;
                    $display("golden step %0d names an unknown port %c", i, port_q[i]);
                end
            endcase
        end

        repeat (4) @(posedge sys_apb_clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== dv/dmi_golden.txt ====
# port op addr wdata exp_rdata exp_err, all hex but the port letter
# port d debug, s system, c system then a debug read of the same address; op 0 nop 1 read 2 write 3 rsvd
d 2 0010 11112222 0 0
d 1 0010 0 11112222 0
d 2 1020 33334444 0 0
d 1 1020 0 33334444 0
d 2 23fc 55556666 0 0
d 1 23fc 0 55556666 0
d 1 1008 0 a5001008 0
d 0 0000 0 a5001008 0
d 3 2000 deadbeef a5001008 0
d 1 3000 0 0 1
d 2 3ffc 12345678 0 1
d 1 0010 0 11112222 0
s 2 0100 cafef00d 0 0
d 1 0100 0 cafef00d 0
d 2 2040 0badc0de 0 0
s 1 2040 0 0badc0de 0
s 1 3010 0 0 1
c 2 1200 a1a1a1a1 a1a1a1a1 0
c 2 0204 b2b2b2b2 b2b2b2b2 0
c 1 0010 0 11112222 0
c 2 2300 c3c3c3c3 c3c3c3c3 0
d 2 0010 77778888 0 0
s 1 0010 0 77778888 0
d 1 1200 0 a1a1a1a1 0
s 1 0204 0 b2b2b2b2 0
d 1 2300 0 c3c3c3c3 0

// ==== sources.f ====
+incdir+rtl
rtl/dmi_pkg.sv
rtl/dmi_apb_master.sv
rtl/dmi_apb_mux.sv
rtl/dmi_apb_decoder.sv
rtl/dmi_top.sv
dv/dmi_properties.sv
dv/dmi_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dmi_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)
